// ==== list.f ====
vin_video_pkg.sv
vin_flow_pkg.sv
vin_ddr_capture.sv
vin_timing_tracker.sv
vin_pixel_convert.sv
vin_stream_out.sv
vin_top.sv
tb_vin_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vin_top -f list.f -o sim_vin

./obj_dir/sim_vin | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb_vin_top.sv ====
// DPI video front end testbench
module tb_vin_top import vin_video_pkg::*, vin_flow_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_RAND_FRAMES = 4;                   // Frames with prompt credit return
    localparam int NUM_FRAMES      = NUM_RAND_FRAMES + 1; // Last one runs with credits held
    localparam int MAX_LINES       = 5;
    localparam int VSYNC_W         = 2;                   // Vsync pulse in pair cycles
    localparam int LEAD_BLANK      = 4;
    localparam int TAIL_BLANK      = 10;

    logic                   clk0_buf;
    logic                   rst_n;
    logic                   dpi_hsync;
    logic                   dpi_vsync;
    logic                   dpi_de;
    logic [DPI_PIXEL_W-1:0] dpi_pixel;
    logic                   credit_return;
    logic                   out_valid;
    logic                   out_sof;
    logic                   out_eol;
    logic [OUT_WORD_W-1:0]  out_data;
    logic [FRAME_CNT_W-1:0] frame_count;
    logic [DROP_CNT_W-1:0]  drop_count;

    int          seed = 47823;
    logic [33:0] exp_q [$];          // {sof, eol, word} in send order
    int          n_lines  [NUM_FRAMES];
    int          vgap     [NUM_FRAMES];
    int          line_len [NUM_FRAMES][MAX_LINES];
    int          hgap     [NUM_FRAMES][MAX_LINES];
    int          stall_words;        // Words in the stalled frame
    int          cycle_limit = 0;
    int          cycles      = 0;
    int          errors      = 0;
    int          checks      = 0;
    int          tests_run   = 0;
    int          sent        = 0;    // Words seen on the output
    int          sof_seen    = 0;
    int          outstanding = 0;    // Sent minus credits returned
    int          ret_wait    = 0;
    logic        credit_hold = 1'b0; // Receiver keeps all credits

    vin_top uut (
        .clk0_buf, .rst_n,
        .dpi_hsync, .dpi_vsync, .dpi_de, .dpi_pixel,
        .credit_return,
        .out_valid, .out_sof, .out_eol, .out_data,
        .frame_count, .drop_count
    );

    initial begin
        clk0_buf = 1'b0;
        forever #2 clk0_buf = ~clk0_buf;   // 4 ns period
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Random RGB666, a quarter of them with red and blue at full scale
    function automatic logic [DPI_PIXEL_W-1:0] rand_pixel();
        logic [DPI_PIXEL_W-1:0] p;
        p = DPI_PIXEL_W'($random(seed));
        if (rand_range(0, 3) == 0) begin
            p[17:12] = 6'h3F;
            p[5:0]   = 6'h3F;
        end
        return p;
    endfunction

    // Red and blue rounded to 5 bits, clamped at 31
    function automatic logic [OUT_PIXEL_W-1:0] to_rgb565(input logic [DPI_PIXEL_W-1:0] p);
        int r;
        int g;
        int b;
        r = (int'(p[17:12]) + 1) / 2;
        b = (int'(p[5:0]) + 1) / 2;
        g = int'(p[11:6]);
        if (r > 31) r = 31;
        if (b > 31) b = 31;
        return {r[4:0], g[5:0], b[4:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // One DDR pair, sync and enable launch with the low pixel after the falling
    // edge so they hold through both capture edges, high pixel after the rising edge
    task automatic drive_pair(input logic hs, input logic vs, input logic de,
                              input logic sof, input logic eol, input logic keep);
        logic [DPI_PIXEL_W-1:0] lo;
        logic [DPI_PIXEL_W-1:0] hi;
        @(negedge clk0_buf);
        #0.5;
        lo = rand_pixel();
        hi = rand_pixel();
        if (de && keep) begin
            exp_q.push_back({sof, eol, to_rgb565(hi), to_rgb565(lo)});   // Low pixel in low half
        end
        dpi_hsync = hs;
        dpi_vsync = vs;
        dpi_de    = de;
        dpi_pixel = lo;
        @(posedge clk0_buf);
        #0.5;
        dpi_pixel = hi;
    endtask

    task automatic send_blank(input int n);
        repeat (n) drive_pair(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    // Words past keep are lost to a full FIFO, so the model skips them
    task automatic send_frame(input int f, input int keep);
        int idx;
        idx = 0;
        repeat (VSYNC_W) drive_pair(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        send_blank(vgap[f]);
        for (int l = 0; l < n_lines[f]; l++) begin
            for (int w = 0; w < line_len[f][l]; w++) begin
                drive_pair(1'b0, 1'b0, 1'b1, (l == 0) && (w == 0),
                           w == line_len[f][l] - 1, idx < keep);
                idx++;
            end
            for (int g = 0; g < hgap[f][l]; g++) begin
                drive_pair(g == 1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);   // Hsync inside hblank
            end
        end
    endtask

    // Line and gap lengths of all frames, known before the run starts
    task automatic build_frame_layout();
        int total;
        total       = LEAD_BLANK + 2 * TAIL_BLANK;
        stall_words = 0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            n_lines[f] = (f < NUM_RAND_FRAMES) ? rand_range(3, 5) : 4;
            vgap[f]    = rand_range(2, 6);
            total      = total + VSYNC_W + vgap[f];
            for (int l = 0; l < n_lines[f]; l++) begin
                line_len[f][l] = (f < NUM_RAND_FRAMES) ? rand_range(4, 12) : rand_range(8, 12);
                hgap[f][l]     = rand_range(3, 8);
                total          = total + line_len[f][l] + hgap[f][l];
                if (f == NUM_FRAMES - 1) stall_words += line_len[f][l];
            end
        end
        cycle_limit = 2 * total + 200;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || outstanding != 0) @(posedge clk0_buf);
        repeat (4) @(posedge clk0_buf);   // Room for any stray word
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errors == err_before) ? "ok" : "failed", errors - err_before);
    endtask

    // Output monitor, samples mid-cycle
    initial begin
        logic [33:0] e;
        forever begin
            @(negedge clk0_buf);
            if (rst_n && out_valid === 1'b1) begin
                sent++;
                if (outstanding >= CREDIT_MAX) begin
                    errors++;
                    $display("Word received while the receiver had no credit left");
                end
                outstanding++;
                if (out_sof) sof_seen++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Word received that the model does not expect");
                end else begin
                    e = exp_q.pop_front();
                    check_value("out_data", out_data, e[31:0]);
                    check_value("out_sof", 32'(out_sof), 32'(e[33]));
                    check_value("out_eol", 32'(out_eol), 32'(e[32]));
                end
            end
        end
    end

    // Credit receiver, one return per cycle after a short random wait
    initial begin
        forever begin
            @(posedge clk0_buf);
            #0.5;
            credit_return = 1'b0;
            if (ret_wait > 0) begin
                ret_wait--;
            end else if (!credit_hold && outstanding > 0) begin
                credit_return = 1'b1;
                outstanding--;
                ret_wait = rand_range(0, 1);
            end
        end
    end

    // Watchdog
    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk0_buf);
            cycles++;
        end
        $display("Timeout after %0d cycles, the output never drained", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int err_mark;
        int sent_mark;
        rst_n         = 1'b0;
        dpi_hsync     = 1'b0;
        dpi_vsync     = 1'b0;
        dpi_de        = 1'b0;
        dpi_pixel     = '0;
        credit_return = 1'b0;
        build_frame_layout();
        repeat (16) @(posedge clk0_buf);
        #0.5;
        rst_n = 1'b1;

        // Reset state
        err_mark = errors;
        @(negedge clk0_buf);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("frame_count", 32'(frame_count), 32'd0);
        check_value("drop_count", 32'(drop_count), 32'd0);
        report_test("reset state", err_mark);

        // Random frames, prompt credits
        err_mark = errors;
        send_blank(LEAD_BLANK);
        for (int f = 0; f < NUM_RAND_FRAMES; f++) send_frame(f, 1 << 30);
        send_blank(TAIL_BLANK);
        wait_drain();
        check_value("frame_count", 32'(frame_count), 32'(NUM_RAND_FRAMES));
        check_value("sof_count", 32'(sof_seen), 32'(NUM_RAND_FRAMES));
        check_value("drop_count", 32'(drop_count), 32'd0);
        report_test("random frames", err_mark);

        // One frame with every credit held back
        err_mark = errors;
        @(negedge clk0_buf);
        credit_hold = 1'b1;
        sent_mark   = sent;
        send_frame(NUM_FRAMES - 1, CREDIT_MAX + FIFO_DEPTH);
        send_blank(TAIL_BLANK);
        check_value("sent_in_stall", 32'(sent - sent_mark), 32'(CREDIT_MAX));
        check_value("drop_count", 32'(drop_count),
                    32'(stall_words - CREDIT_MAX - FIFO_DEPTH));
        @(negedge clk0_buf);
        credit_hold = 1'b0;
        wait_drain();
        check_value("sent_after_stall", 32'(sent - sent_mark), 32'(CREDIT_MAX + FIFO_DEPTH));
        check_value("frame_count", 32'(frame_count), 32'(NUM_FRAMES));
        check_value("sof_count", 32'(sof_seen), 32'(NUM_FRAMES));
        report_test("credit stall", err_mark);

        $display("%0d tests, %0d checks, %0d words, %0d errors",
                 tests_run, checks, sent, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== vin_ddr_capture.sv ====
// DPI DDR input capture
module vin_ddr_capture import vin_video_pkg::*; (
    input  logic                   clk0_buf,
    input  logic                   rst_n,
    input  logic                   dpi_hsync,
    input  logic                   dpi_vsync,
    input  logic                   dpi_de,
    input  logic [DPI_PIXEL_W-1:0] dpi_pixel,
    output logic                   cap_hsync,
    output logic                   cap_vsync,
    output logic                   cap_de,
    output logic [PAIR_W-1:0]      cap_pixel_pair
);

    // First stage, one register per clock edge
    logic [DPI_PIXEL_W-1:0] pix_rise;   // Pixel seen on the rising edge
    logic [DPI_PIXEL_W-1:0] pix_fall;   // Pixel seen on the following falling edge
    logic                   hs_rise;
    logic                   vs_rise;
    logic                   de_rise;

    // Sync and enable only sampled on the rising edge
    always_ff @(posedge clk0_buf) begin
        if (!rst_n) begin
            hs_rise   <= 1'b0;
            vs_rise   <= 1'b0;
            de_rise   <= 1'b0;
            cap_hsync <= 1'b0;
            cap_vsync <= 1'b0;
            cap_de    <= 1'b0;
        end else begin
            hs_rise   <= dpi_hsync;
            vs_rise   <= dpi_vsync;
            de_rise   <= dpi_de;
            cap_hsync <= hs_rise;   // Realigned with the pixel pair
            cap_vsync <= vs_rise;
            cap_de    <= de_rise;
        end
    end

    always_ff @(posedge clk0_buf) begin
        pix_rise       <= dpi_pixel;
        cap_pixel_pair <= {pix_fall, pix_rise};   // Falling pixel lands in the high half
    end

    always_ff @(negedge clk0_buf) begin
        pix_fall <= dpi_pixel;   // Second half of the pair
    end

    // Enable must hold from the rising edge through the falling edge
    // so both pixels of a pair share one cap_de
    a_de_stable_in_pair: assert property (
        @(negedge clk0_buf) disable iff (!rst_n) dpi_de == de_rise
    );

endmodule

// ==== vin_flow_pkg.sv ====
// Stream flow control definitions
package vin_flow_pkg;

    // Video timing tracker states
    typedef enum logic [1:0] {
        wait_vsync  = 2'd0,   // Not locked yet, no frame seen
        vblank      = 2'd1,   // After vsync, before the first line
        active_line = 2'd2,   // Enable high, words flowing
        hblank      = 2'd3    // Between two lines of a frame
    } tracker_state_t;

    // Output FIFO
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;                    // log2 of FIFO_DEPTH

    // Credit handshake with the receiver
    localparam int CREDIT_MAX = 8;                    // Credits held after reset
    localparam int CREDIT_W   = 4;

    // Words lost to a full FIFO
    localparam int DROP_CNT_W = 16;

endpackage

// ==== vin_pixel_convert.sv ====
// RGB666 to RGB565 pixel converter
module vin_pixel_convert import vin_video_pkg::*; (
    input  logic                  clk0_buf,
    input  logic                  rst_n,
    input  logic [PAIR_W-1:0]     cap_pixel_pair,
    output logic [OUT_WORD_W-1:0] conv_word
);

    // Rounded channels per pixel of the pair
    logic [CH5_W-1:0] red_q [PIXELS_PER_WORD];
    logic [CH6_W-1:0] grn_q [PIXELS_PER_WORD];
    logic [CH5_W-1:0] blu_q [PIXELS_PER_WORD];

    // Add half an LSB, drop one bit, clamp 63 to 31
    function automatic logic [CH5_W-1:0] round_ch(input logic [CH6_W-1:0] ch);
        logic [CH6_W:0] sum;
        sum = {1'b0, ch} + 1'b1;
        if (sum[CH6_W:1] > CH5_MAX) begin
            round_ch = CH5_MAX[CH5_W-1:0];
        end else begin
            round_ch = sum[CH5_W:1];
        end
    endfunction

    // Stage one, rounding
    always_ff @(posedge clk0_buf) begin
        if (!rst_n) begin
            for (int p = 0; p < PIXELS_PER_WORD; p++) begin
                red_q[p] <= '0;
                grn_q[p] <= '0;
                blu_q[p] <= '0;
            end
        end else begin
            for (int p = 0; p < PIXELS_PER_WORD; p++) begin
                red_q[p] <= round_ch(cap_pixel_pair[p*DPI_PIXEL_W + DPI_R_LSB +: CH6_W]);
                grn_q[p] <= cap_pixel_pair[p*DPI_PIXEL_W + DPI_G_LSB +: CH6_W];  // Green keeps 6 bits
                blu_q[p] <= round_ch(cap_pixel_pair[p*DPI_PIXEL_W + DPI_B_LSB +: CH6_W]);
            end
        end
    end

    // Stage two, pack each pixel as R5 G6 B5
    always_ff @(posedge clk0_buf) begin
        if (!rst_n) begin
            conv_word <= '0;
        end else begin
            for (int p = 0; p < PIXELS_PER_WORD; p++) begin
                conv_word[p*OUT_PIXEL_W +: OUT_PIXEL_W] <= {red_q[p], grn_q[p], blu_q[p]};
            end
        end
    end

endmodule

// ==== vin_stream_out.sv ====
// Tagged pixel stream output with credits
module vin_stream_out import vin_video_pkg::*, vin_flow_pkg::*; (
    input  logic                  clk0_buf,
    input  logic                  rst_n,
    input  logic                  trk_valid,
    input  logic                  trk_sof,
    input  logic                  trk_eol,
    input  logic [OUT_WORD_W-1:0] conv_word,
    input  logic                  credit_return,
    output logic                  out_valid,
    output logic                  out_sof,
    output logic                  out_eol,
    output logic [OUT_WORD_W-1:0] out_data,
    output logic [DROP_CNT_W-1:0] drop_count
);

    // FIFO storage holding each word beside its tags
    logic [OUT_WORD_W-1:0] word_mem [FIFO_DEPTH];
    logic                  sof_mem  [FIFO_DEPTH];
    logic                  eol_mem  [FIFO_DEPTH];

    logic [FIFO_AW:0]      wr_ptr;       // Extra bit tells full from empty
    logic [FIFO_AW:0]      rd_ptr;
    logic [FIFO_AW:0]      fill;         // Words currently held
    logic                  fifo_full;
    logic                  fifo_empty;
    logic                  push;
    logic                  drop;
    logic                  pop;
    logic [CREDIT_W-1:0]   credit_cnt;   // Words the receiver can still take

    assign fill       = wr_ptr - rd_ptr;
    assign fifo_full  = (fill == FIFO_DEPTH);
    assign fifo_empty = (wr_ptr == rd_ptr);

    assign push = trk_valid && !fifo_full;
    assign drop = trk_valid && fifo_full;             // Live video cannot stall the source
    assign pop  = !fifo_empty && (credit_cnt != '0);  // One send per cycle at most

    // Tags and pixels arrive aligned on the write side
    always_ff @(posedge clk0_buf) begin
        if (push) begin
            word_mem[wr_ptr[FIFO_AW-1:0]] <= conv_word;
            sof_mem[wr_ptr[FIFO_AW-1:0]]  <= trk_sof;
            eol_mem[wr_ptr[FIFO_AW-1:0]]  <= trk_eol;
        end
    end

    always_ff @(posedge clk0_buf) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Credit counter where a send and a return can share a cycle
    always_ff @(posedge clk0_buf) begin
        if (!rst_n) begin
            credit_cnt <= CREDIT_MAX[CREDIT_W-1:0];
        end else begin
            case ({pop, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;   // Both or neither leaves the count
            endcase
        end
    end

    // Output register with tags qualified by the send
    always_ff @(posedge clk0_buf) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_sof   <= 1'b0;
            out_eol   <= 1'b0;
        end else begin
            out_valid <= pop;
            out_sof   <= pop && sof_mem[rd_ptr[FIFO_AW-1:0]];
            out_eol   <= pop && eol_mem[rd_ptr[FIFO_AW-1:0]];
        end
    end

    always_ff @(posedge clk0_buf) begin
        if (pop) begin
            out_data <= word_mem[rd_ptr[FIFO_AW-1:0]];   // Holds last word between sends
        end
    end

    // Saturating count of dropped words
    always_ff @(posedge clk0_buf) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (drop && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    // Receiver returned more than it was sent
    a_credit_bound: assert property (
        @(posedge clk0_buf) disable iff (!rst_n) credit_cnt <= CREDIT_MAX
    );

    // Pointer distance stays within the storage
    a_fifo_bound: assert property (
        @(posedge clk0_buf) disable iff (!rst_n) fill <= FIFO_DEPTH
    );

endmodule

// ==== vin_timing_tracker.sv ====
// Video timing tracker
module vin_timing_tracker import vin_video_pkg::*, vin_flow_pkg::*; (
    input  logic                   clk0_buf,
    input  logic                   rst_n,
    input  logic                   cap_hsync,
    input  logic                   cap_vsync,
    input  logic                   cap_de,
    output logic                   trk_valid,
    output logic                   trk_sof,
    output logic                   trk_eol,
    output logic [FRAME_CNT_W-1:0] frame_count
);

    tracker_state_t state;
    tracker_state_t next_state;
    logic           vs_d;        // Vsync one cycle back, for edge detect
    logic           vs_edge;     // Rising edge of vsync
    logic           word_now;    // Current cap word belongs to a line
    logic           word_d;      // Same, one cycle back
    logic           sof_d;       // Delayed word is first of its frame

    assign vs_edge = cap_vsync & ~vs_d;

    always_comb begin
        next_state = state;
        if (vs_edge) begin
            next_state = vblank;                         // New frame from any state
        end else begin
            case (state)
                wait_vsync:  next_state = wait_vsync;    // Hold until the first vsync
                vblank: begin
                    if (cap_de && !cap_hsync) begin
                        next_state = active_line;        // First line of the frame
                    end
                end
                active_line: begin
                    if (!cap_de || cap_hsync) begin
                        next_state = hblank;             // Enable fell, or hsync cuts the line
                    end
                end
                hblank: begin
                    if (cap_de && !cap_hsync) begin
                        next_state = active_line;
                    end
                end
                default:     next_state = wait_vsync;
            endcase
        end
    end

    // Only words inside a tracked line go downstream
    assign word_now = cap_de && (next_state == active_line);

    // Stage one, state and delayed enable
    always_ff @(posedge clk0_buf) begin
        if (!rst_n) begin
            state  <= wait_vsync;
            vs_d   <= 1'b0;
            word_d <= 1'b0;
            sof_d  <= 1'b0;
        end else begin
            state  <= next_state;
            vs_d   <= cap_vsync;
            word_d <= word_now;
            sof_d  <= word_now && (state == vblank);   // Leaving vblank marks frame start
        end
    end

    // Stage two, tags with one word of look-ahead
    always_ff @(posedge clk0_buf) begin
        if (!rst_n) begin
            trk_valid   <= 1'b0;
            trk_sof     <= 1'b0;
            trk_eol     <= 1'b0;
            frame_count <= '0;
        end else begin
            trk_valid <= word_d;
            trk_sof   <= sof_d;
            trk_eol   <= word_d && !word_now;   // Next word is not part of this line
            if (sof_d) begin
                frame_count <= frame_count + 1'b1;   // Wraps after 65535 frames
            end
        end
    end

endmodule

// ==== vin_top.sv ====
// DPI video input front end
module vin_top import vin_video_pkg::*, vin_flow_pkg::*; (
    input  logic                   clk0_buf,
    input  logic                   rst_n,
    input  logic                   dpi_hsync,
    input  logic                   dpi_vsync,
    input  logic                   dpi_de,
    input  logic [DPI_PIXEL_W-1:0] dpi_pixel,
    input  logic                   credit_return,
    output logic                   out_valid,
    output logic                   out_sof,
    output logic                   out_eol,
    output logic [OUT_WORD_W-1:0]  out_data,
    output logic [FRAME_CNT_W-1:0] frame_count,
    output logic [DROP_CNT_W-1:0]  drop_count
);

    // Capture outputs, one pair per cycle
    logic                  cap_hsync;
    logic                  cap_vsync;
    logic                  cap_de;
    logic [PAIR_W-1:0]     cap_pixel_pair;

    // Parallel paths, both two cycles deep
    logic                  trk_valid;
    logic                  trk_sof;
    logic                  trk_eol;
    logic [OUT_WORD_W-1:0] conv_word;

    vin_ddr_capture u_capture (
        .clk0_buf, .rst_n,
        .dpi_hsync, .dpi_vsync, .dpi_de, .dpi_pixel,
        .cap_hsync, .cap_vsync, .cap_de, .cap_pixel_pair
    );

    vin_timing_tracker u_tracker (
        .clk0_buf, .rst_n,
        .cap_hsync, .cap_vsync, .cap_de,
        .trk_valid, .trk_sof, .trk_eol, .frame_count
    );

    vin_pixel_convert u_convert (
        .clk0_buf, .rst_n,
        .cap_pixel_pair, .conv_word
    );

    vin_stream_out u_stream (
        .clk0_buf, .rst_n,
        .trk_valid, .trk_sof, .trk_eol, .conv_word, .credit_return,
        .out_valid, .out_sof, .out_eol, .out_data, .drop_count
    );

endmodule

// ==== vin_video_pkg.sv ====
// DPI video format definitions
package vin_video_pkg;

    // DPI input side, RGB666 with red in the top bits
    localparam int DPI_PIXEL_W     = 18;
    localparam int CH6_W           = 6;                  // One input colour channel
    localparam int DPI_R_LSB       = 12;                 // Red in [17:12]
    localparam int DPI_G_LSB       = 6;                  // Green in [11:6]
    localparam int DPI_B_LSB       = 0;                  // Blue in [5:0]

    // Two pixels per clk0_buf cycle
    localparam int PIXELS_PER_WORD = 2;
    localparam int PAIR_W          = PIXELS_PER_WORD * DPI_PIXEL_W;  // Rising pixel low, falling high

    // RGB565 output side
    localparam int CH5_W           = 5;                  // Red and blue after rounding
    localparam int CH5_MAX         = 31;                 // Saturation point of a rounded channel
    localparam int OUT_PIXEL_W     = 16;
    localparam int OUT_WORD_W      = PIXELS_PER_WORD * OUT_PIXEL_W;

    // Frame statistics
    localparam int FRAME_CNT_W     = 16;

endpackage
